// ==== design/apb_reg_decode.sv ====
`timescale 1ns/1ns

module apb_reg_decode
#(
	parameter logic [9:0] P_BASE_ADDR = 10'h004
)
(
	input  logic                  i_PCLK,
	input  logic                  i_PRESETn,
	input  logic                  i_PSEL,
	input  logic                  i_PENABLE,
	input  logic                  i_PWRITE,
	input  logic [15:0]           i_PADDR,
	input  logic [7:0]            i_PWDATA,
	output logic                  o_PREADY,
	output apb_spi_pkg::reg_wr_t  o_wr,
	output apb_spi_pkg::reg_sel_e o_rd_sel
);

	import apb_spi_pkg::*;

	logic     penable_q;    // PENABLE one cycle ago
	logic     enable_rise;  // First access cycle
	logic     base_hit;     // High address bits match
	reg_sel_e offset;       // Low address bits as register offset

	assign o_PREADY = i_PSEL & i_PENABLE; // No wait states

	assign base_hit    = (i_PADDR[15:6] == P_BASE_ADDR);
	assign offset      = reg_sel_e'(i_PADDR[5:2]);
	assign enable_rise = i_PENABLE & ~penable_q;

	always_ff @(posedge i_PCLK)
	begin
		if (!i_PRESETn)
			penable_q <= 1'b0;
		else
			penable_q <= i_PENABLE;
	end

	// Strobes appear in the cycle after the access cycle
	always_ff @(posedge i_PCLK)
	begin
		if (!i_PRESETn)
		begin
			o_wr <= '0;
		end
		else
		begin
			o_wr.wr_cfg <= 1'b0;
			o_wr.wr_tx  <= 1'b0;
			o_wr.wr_cmd <= 1'b0;
			if (i_PSEL && enable_rise && i_PWRITE && base_hit)
			begin
				o_wr.wdata <= i_PWDATA;
				case (offset)
					REG_CFG_STAT: o_wr.wr_cfg <= 1'b1;
					REG_DATA:     o_wr.wr_tx  <= 1'b1;
					REG_CMD:      o_wr.wr_cmd <= 1'b1;
					default:      ;                    // Unmapped offset is ignored
				endcase
			end
		end
	end

	// Read select must be valid while PREADY is high
	always_comb
	begin
		o_rd_sel = REG_NONE;
		if (i_PSEL && i_PENABLE && !i_PWRITE && base_hit)
			o_rd_sel = offset;
	end

endmodule

// ==== design/apb_spi_pkg.sv ====
package apb_spi_pkg;

	// Write strobes from the APB decoder, one cycle wide
	typedef struct packed
	{
		logic       wr_cfg;    // Offset 0 write
		logic       wr_tx;     // Offset 1 write
		logic       wr_cmd;    // Offset 2 write
		logic [7:0] wdata;     // Captured PWDATA
	} reg_wr_t;

	// Configuration register, bit 7 down to bit 0
	typedef struct packed
	{
		logic       enable;    // Allows START
		logic       loopback;  // Receive from own TX line
		logic [5:0] clk_div;   // Bit slot is clk_div+1 cycles
	} cfg_t;

	// Status register as seen on a read of offset 0
	typedef struct packed
	{
		logic [4:0] rsvd;      // Reads as zero
		logic       overrun;   // START seen while busy
		logic       done;      // Last transfer finished
		logic       busy;      // Transfer in progress
	} status_t;

	// Command opcodes, low two bits of a write to offset 2
	typedef enum logic [1:0]
	{
		CMD_NOP   = 2'd0,
		CMD_START = 2'd1,
		CMD_CLEAR = 2'd2      // Clears done and overrun
	} cmd_op_e;

	// Transfer controller states
	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_LOAD,
		ST_SHIFT,
		ST_DONE
	} xfer_state_e;

	// Register offsets, taken from PADDR[5:2]
	typedef enum logic [3:0]
	{
		REG_CFG_STAT = 4'd0,   // W config, R status
		REG_DATA     = 4'd1,   // W tx byte, R rx byte
		REG_CMD      = 4'd2,   // W command, R config
		REG_NONE     = 4'd15   // No read in progress
	} reg_sel_e;

endpackage

// ==== design/apb_spi_top.sv ====
`timescale 1ns/1ns

module apb_spi_top
#(
	parameter logic [9:0] P_BASE_ADDR = 10'h004
)
(
	input  logic        i_PCLK,
	input  logic        i_PRESETn,
	input  logic        i_PSEL,
	input  logic        i_PENABLE,
	input  logic        i_PWRITE,
	input  logic [15:0] i_PADDR,
	input  logic [7:0]  i_PWDATA,
	output logic        o_PREADY,
	output logic [7:0]  o_PRDATA,
	input  logic        i_rx,
	output logic        o_tx,
	output logic        o_pkt_rec
);

	import apb_spi_pkg::*;

	reg_wr_t    wr;
	reg_sel_e   rd_sel;
	cfg_t       cfg;
	status_t    status;
	logic [7:0] tx_byte;
	logic [7:0] rx_byte;
	logic       start_req;
	logic       clear_req;
	logic       rx_load;
	logic       load;
	logic       timer_run;
	logic       bit_tick;
	logic       last_tick;

	apb_reg_decode #(.P_BASE_ADDR(P_BASE_ADDR)) apb_reg_decode_i
	(
		.i_PCLK    (i_PCLK),
		.i_PRESETn (i_PRESETn),
		.i_PSEL    (i_PSEL),
		.i_PENABLE (i_PENABLE),
		.i_PWRITE  (i_PWRITE),
		.i_PADDR   (i_PADDR),
		.i_PWDATA  (i_PWDATA),
		.o_PREADY  (o_PREADY),
		.o_wr      (wr),
		.o_rd_sel  (rd_sel)
	);

	spi_reg_bank spi_reg_bank_i
	(
		.i_PCLK      (i_PCLK),
		.i_PRESETn   (i_PRESETn),
		.i_wr        (wr),
		.i_rd_sel    (rd_sel),
		.i_status    (status),
		.i_rx_load   (rx_load),
		.i_rx_byte   (rx_byte),
		.o_PRDATA    (o_PRDATA),
		.o_cfg       (cfg),
		.o_tx_byte   (tx_byte),
		.o_start_req (start_req),
		.o_clear_req (clear_req)
	);

	spi_ctrl_fsm spi_ctrl_fsm_i
	(
		.i_PCLK      (i_PCLK),
		.i_PRESETn   (i_PRESETn),
		.i_start_req (start_req),
		.i_clear_req (clear_req),
		.i_last_tick (last_tick),
		.o_load      (load),
		.o_timer_run (timer_run),
		.o_rx_load   (rx_load),
		.o_pkt_rec   (o_pkt_rec),
		.o_status    (status)
	);

	spi_bit_timer spi_bit_timer_i
	(
		.i_PCLK      (i_PCLK),
		.i_PRESETn   (i_PRESETn),
		.i_run       (timer_run),
		.i_clk_div   (cfg.clk_div),
		.o_bit_tick  (bit_tick),
		.o_last_tick (last_tick)
	);

	spi_shift_reg spi_shift_reg_i
	(
		.i_PCLK     (i_PCLK),
		.i_PRESETn  (i_PRESETn),
		.i_load     (load),
		.i_tx_byte  (tx_byte),
		.i_bit_tick (bit_tick),
		.i_loopback (cfg.loopback),
		.i_busy     (status.busy),
		.i_rx       (i_rx),
		.o_tx       (o_tx),
		.o_rx_byte  (rx_byte)
	);

endmodule

// ==== design/spi_bit_timer.sv ====
`timescale 1ns/1ns

module spi_bit_timer
(
	input  logic       i_PCLK,
	input  logic       i_PRESETn,
	input  logic       i_run,
	input  logic [5:0] i_clk_div,
	output logic       o_bit_tick,
	output logic       o_last_tick
);

	logic [5:0] div_cnt;   // Cycles within the current slot
	logic [2:0] slot_cnt;  // Slots completed so far
	logic       slot_end;

	// Compare with >= so a smaller divider mid-transfer still wraps
	assign slot_end = (div_cnt >= i_clk_div);

	always_ff @(posedge i_PCLK)
	begin
		if (!i_PRESETn || !i_run)
		begin
			div_cnt  <= '0;
			slot_cnt <= '0;
		end
		else if (slot_end)
		begin
			div_cnt  <= '0;
			slot_cnt <= slot_cnt + 3'd1;
		end
		else
		begin
			div_cnt <= div_cnt + 6'd1;
		end
	end

	assign o_bit_tick  = i_run & slot_end;
	assign o_last_tick = o_bit_tick & (slot_cnt == 3'd7); // Eighth slot

endmodule

// ==== design/spi_ctrl_fsm.sv ====
`timescale 1ns/1ns

module spi_ctrl_fsm
(
	input  logic                 i_PCLK,
	input  logic                 i_PRESETn,
	input  logic                 i_start_req,
	input  logic                 i_clear_req,
	input  logic                 i_last_tick,
	output logic                 o_load,
	output logic                 o_timer_run,
	output logic                 o_rx_load,
	output logic                 o_pkt_rec,
	output apb_spi_pkg::status_t o_status
);

	import apb_spi_pkg::*;

	xfer_state_e state_q;
	xfer_state_e state_d;
	logic        done_q;     // Sticky until CLEAR or next START
	logic        overrun_q;  // Sticky until CLEAR

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:  if (i_start_req) state_d = ST_LOAD;
			ST_LOAD:  state_d = ST_SHIFT;               // Single cycle
			ST_SHIFT: if (i_last_tick) state_d = ST_DONE;
			ST_DONE:  state_d = ST_IDLE;
			default:  state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_PCLK)
	begin
		if (!i_PRESETn)
		begin
			state_q   <= ST_IDLE;
			done_q    <= 1'b0;
			overrun_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			if (i_clear_req)
			begin
				done_q    <= 1'b0;
				overrun_q <= 1'b0;
			end
			// Set conditions take priority over CLEAR
			if (i_start_req && state_q == ST_IDLE)
				done_q <= 1'b0;
			if (state_q == ST_DONE)
				done_q <= 1'b1;
			if (i_start_req && state_q != ST_IDLE)
				overrun_q <= 1'b1; // Request itself is dropped
		end
	end

	assign o_load      = (state_q == ST_LOAD);
	assign o_timer_run = (state_q == ST_SHIFT);
	assign o_rx_load   = (state_q == ST_DONE);
	assign o_pkt_rec   = (state_q == ST_DONE);

	always_comb
	begin
		o_status         = '0;
		o_status.busy    = (state_q != ST_IDLE);
		o_status.done    = done_q;
		o_status.overrun = overrun_q;
	end

endmodule

// ==== design/spi_reg_bank.sv ====
`timescale 1ns/1ns

module spi_reg_bank
(
	input  logic                  i_PCLK,
	input  logic                  i_PRESETn,
	input  apb_spi_pkg::reg_wr_t  i_wr,
	input  apb_spi_pkg::reg_sel_e i_rd_sel,
	input  apb_spi_pkg::status_t  i_status,
	input  logic                  i_rx_load,
	input  logic [7:0]            i_rx_byte,
	output logic [7:0]            o_PRDATA,
	output apb_spi_pkg::cfg_t     o_cfg,
	output logic [7:0]            o_tx_byte,
	output logic                  o_start_req,
	output logic                  o_clear_req
);

	import apb_spi_pkg::*;

	cfg_t       cfg_q;    // Configuration register
	logic [7:0] tx_q;     // Byte to send
	logic [7:0] rx_q;     // Last byte received
	cmd_op_e    cmd_op;   // Decoded command write

	assign cmd_op = cmd_op_e'(i_wr.wdata[1:0]);

	always_ff @(posedge i_PCLK)
	begin
		if (!i_PRESETn)
		begin
			cfg_q <= '0;
			tx_q  <= '0;
			rx_q  <= '0;
		end
		else
		begin
			if (i_wr.wr_cfg)
				cfg_q <= cfg_t'(i_wr.wdata);
			if (i_wr.wr_tx)
				tx_q <= i_wr.wdata;
			if (i_rx_load)
				rx_q <= i_rx_byte; // Latched when controller finishes
		end
	end

	// A START with the block disabled is simply dropped
	assign o_start_req = i_wr.wr_cmd & (cmd_op == CMD_START) & cfg_q.enable;
	assign o_clear_req = i_wr.wr_cmd & (cmd_op == CMD_CLEAR);

	always_comb
	begin
		case (i_rd_sel)
			REG_CFG_STAT: o_PRDATA = i_status;
			REG_DATA:     o_PRDATA = rx_q;
			REG_CMD:      o_PRDATA = cfg_q;   // Config readback
			default:      o_PRDATA = 8'h00;
		endcase
	end

	assign o_cfg     = cfg_q;
	assign o_tx_byte = tx_q;

endmodule

// ==== design/spi_shift_reg.sv ====
`timescale 1ns/1ns

module spi_shift_reg
(
	input  logic       i_PCLK,
	input  logic       i_PRESETn,
	input  logic       i_load,
	input  logic [7:0] i_tx_byte,
	input  logic       i_bit_tick,
	input  logic       i_loopback,
	input  logic       i_busy,
	input  logic       i_rx,
	output logic       o_tx,
	output logic [7:0] o_rx_byte
);

	logic [7:0] shift_q;  // TX bits leave at the top, RX bits enter at the bottom
	logic       rx_bit;

	// Line idles high between transfers
	assign o_tx = i_busy ? shift_q[7] : 1'b1;

	assign rx_bit = i_loopback ? o_tx : i_rx;

	always_ff @(posedge i_PCLK)
	begin
		if (!i_PRESETn)
		begin
			shift_q <= '0;
		end
		else if (i_load)
		begin
			shift_q <= i_tx_byte;
		end
		else if (i_bit_tick)
		begin
			shift_q <= {shift_q[6:0], rx_bit}; // MSB first
		end
	end

	// Complete after the eighth shift
	assign o_rx_byte = shift_q;

endmodule

// ==== filelist.f ====
design/apb_spi_pkg.sv
design/apb_reg_decode.sv
design/spi_reg_bank.sv
design/spi_ctrl_fsm.sv
design/spi_bit_timer.sv
design/spi_shift_reg.sv
design/apb_spi_top.sv
testbench/apb_spi_checker.sv
testbench/tb_apb_spi.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the APB serial peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_apb_spi \
	-f filelist.f \
	-o sim_apb_spi

out=$(./obj_dir/sim_apb_spi +verilator+error+limit+100 || true)
echo "$out"

if echo "$out" | grep -qxF '*** PASSED ***'
then
	exit 0
fi
exit 1

// ==== testbench/apb_spi_checker.sv ====
`timescale 1ns/1ns

module apb_spi_checker
(
	input logic                 i_PCLK,
	input logic                 i_PRESETn,
	input logic                 i_PSEL,
	input logic                 i_PENABLE,
	input logic                 i_PREADY,
	input logic                 i_pkt_rec,
	input logic                 i_tx,
	input apb_spi_pkg::status_t i_status
);

	int ready_fails = 0;
	int pulse_fails = 0;
	int idle_fails  = 0;
	int reset_fails = 0;
	int fail_count;

	assign fail_count = ready_fails + pulse_fails + idle_fails + reset_fails;

	// No wait states on the bus
	ready_follows_enable: assert property (@(posedge i_PCLK) i_PREADY == (i_PSEL && i_PENABLE))
		else
		begin
			$error("PREADY differs from PSEL and PENABLE");
			ready_fails++;
		end

	pkt_rec_one_cycle: assert property (@(posedge i_PCLK) disable iff (!i_PRESETn)
		i_pkt_rec |=> !i_pkt_rec)
		else
		begin
			$error("o_pkt_rec stayed high for two cycles");
			pulse_fails++;
		end

	tx_idles_high: assert property (@(posedge i_PCLK) disable iff (!i_PRESETn)
		!i_status.busy |-> i_tx)
		else
		begin
			$error("o_tx low while no transfer is busy");
			idle_fails++;
		end

	pkt_rec_low_in_reset: assert property (@(posedge i_PCLK) !i_PRESETn |=> !i_pkt_rec)
		else
		begin
			$error("o_pkt_rec high during reset");
			reset_fails++;
		end

endmodule

bind apb_spi_top apb_spi_checker apb_spi_checker_i
(
	.i_PCLK    (i_PCLK),
	.i_PRESETn (i_PRESETn),
	.i_PSEL    (i_PSEL),
	.i_PENABLE (i_PENABLE),
	.i_PREADY  (o_PREADY),
	.i_pkt_rec (o_pkt_rec),
	.i_tx      (o_tx),
	.i_status  (status)
);

// ==== testbench/tb_apb_spi.sv ====
`timescale 1ns/1ns

module tb_apb_spi;

	import apb_spi_pkg::*;

	localparam logic [9:0] BASE  = 10'h004;
	localparam int         LIMIT = 1000;   // Cycles before a wait gives up

	logic        i_PCLK;
	logic        i_PRESETn;
	logic        i_PSEL;
	logic        i_PENABLE;
	logic        i_PWRITE;
	logic [15:0] i_PADDR;
	logic [7:0]  i_PWDATA;
	logic        i_rx;
	logic        o_PREADY;
	logic [7:0]  o_PRDATA;
	logic        o_tx;
	logic        o_pkt_rec;

	integer seed;
	int     errors;
	int     tests;
	int     errors_before;
	string  test_name;
	logic   tx_trace[$];   // o_tx at each negedge while waiting for o_pkt_rec

	apb_spi_top #(.P_BASE_ADDR(BASE)) apb_spi_top_i (.*);

	initial
	begin
		i_PCLK = 1'b0;
		forever #50 i_PCLK = ~i_PCLK;
	end

	function automatic logic [7:0] rand_byte();
		integer r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic status_t make_status(input logic busy, input logic done, input logic ovr);
		status_t s;
		s         = '0;
		s.busy    = busy;
		s.done    = done;
		s.overrun = ovr;
		return s;
	endfunction

	function automatic cfg_t make_cfg(input logic en, input logic lb, input logic [5:0] div);
		cfg_t c;
		c.enable   = en;
		c.loopback = lb;
		c.clk_div  = div;
		return c;
	endfunction

	// Setup cycle, then access cycle held until PREADY
	task automatic apb_access(input logic write, input logic [9:0] base,
		input logic [3:0] offset, input logic [7:0] wdata, output logic [7:0] rdata);
		int cycles;
		cycles = 0;
		@(posedge i_PCLK);
		i_PSEL    <= 1'b1;
		i_PENABLE <= 1'b0;
		i_PWRITE  <= write;
		i_PADDR   <= {base, offset, 2'b00};
		i_PWDATA  <= wdata;
		@(posedge i_PCLK);
		i_PENABLE <= 1'b1;
		@(negedge i_PCLK);
		while (!o_PREADY && cycles < LIMIT)
		begin
			@(negedge i_PCLK);
			cycles++;
		end
		if (!o_PREADY)
		begin
			$display("%s: PREADY never came during an APB access", test_name);
			errors++;
		end
		rdata = o_PRDATA;   // Mid-cycle, stable
		@(posedge i_PCLK);
		i_PSEL    <= 1'b0;
		i_PENABLE <= 1'b0;
		i_PWRITE  <= 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] offset, input logic [7:0] data,
		input logic [9:0] base = BASE);
		logic [7:0] unused;
		apb_access(1'b1, base, offset, data, unused);
	endtask

	task automatic apb_read(input logic [3:0] offset, output logic [7:0] data,
		input logic [9:0] base = BASE);
		apb_access(1'b0, base, offset, 8'h00, data);
	endtask

	task automatic wait_pkt_rec(input int max_cycles, output bit seen);
		int cycles;
		cycles = 0;
		seen   = 1'b0;
		tx_trace.delete();
		while (!seen && cycles < max_cycles)
		begin
			@(negedge i_PCLK);
			tx_trace.push_back(o_tx);
			seen = o_pkt_rec;
			cycles++;
		end
	endtask

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
		begin
			$display("FAILED %s: %s expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_status(input string what, input status_t exp, input status_t act);
		if (act !== exp)
		begin
			$display("FAILED %s: %s expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_cfg(input string what, input cfg_t exp, input cfg_t act);
		if (act !== exp)
		begin
			$display("FAILED %s: %s expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	// Eight slots of div+1 cycles end in the cycle before o_pkt_rec
	task automatic check_tx_bits(input logic [7:0] exp, input logic [5:0] div);
		int         slot;
		int         idx;
		logic [7:0] act;
		act = 8'h00;
		for (slot = 0; slot < 8; slot++)
		begin
			idx = tx_trace.size() - 2 - (7 - slot) * (int'(div) + 1);
			if (idx >= 0)
				act[7 - slot] = tx_trace[idx];   // Last cycle of the slot
			else
				act[7 - slot] = 1'bx;
		end
		check_byte("bits on o_tx, MSB first", exp, act);
	endtask

	task automatic begin_test(input string name);
		test_name     = name;
		errors_before = errors;
		tests++;
	endtask

	task automatic end_test();
		$display("test %s finished with %0d errors", test_name, errors - errors_before);
	endtask

	// Load the byte, issue START and wait for the packet
	task automatic send_byte(input logic [7:0] data);
		bit seen;
		apb_write(REG_DATA, data);
		apb_write(REG_CMD, 8'(CMD_START));
		wait_pkt_rec(LIMIT, seen);
		if (!seen)
		begin
			$display("%s: timeout, o_pkt_rec did not arrive after START", test_name);
			errors++;
		end
	endtask

	task automatic reset_and_access();
		logic [7:0] rd;
		cfg_t       cfg;
		begin_test("reset_and_access");
		apb_read(REG_CFG_STAT, rd);
		check_status("status after reset", make_status(1'b0, 1'b0, 1'b0), status_t'(rd));
		apb_read(REG_CMD, rd);
		check_cfg("config after reset", '0, cfg_t'(rd));
		apb_read(REG_DATA, rd);
		check_byte("rx byte after reset", 8'h00, rd);
		cfg = '0;
		repeat (4)
		begin
			cfg = cfg_t'(rand_byte());
			apb_write(REG_CFG_STAT, cfg);
			apb_read(REG_CMD, rd);
			check_cfg("config readback", cfg, cfg_t'(rd));
		end
		for (int off = 3; off < 16; off++)
		begin
			apb_read(4'(off), rd);
			check_byte("unmapped offset", 8'h00, rd);
		end
		apb_write(REG_CFG_STAT, ~cfg, BASE + 10'd1);   // Other base
		apb_read(REG_CMD, rd);
		check_cfg("config after foreign write", cfg, cfg_t'(rd));
		apb_read(REG_CMD, rd, BASE + 10'd1);
		check_byte("foreign base read", 8'h00, rd);
		end_test();
	endtask

	task automatic loopback_transfer();
		logic [7:0] rd;
		logic [7:0] sent;
		logic [5:0] div;
		begin_test("loopback_transfer");
		for (int i = 0; i < 2; i++)
		begin
			div = 6'(3 * i);
			apb_write(REG_CFG_STAT, make_cfg(1'b1, 1'b1, div));
			sent = rand_byte();
			send_byte(sent);
			check_tx_bits(sent, div);
			apb_read(REG_DATA, rd);
			check_byte("looped back byte", sent, rd);
			apb_read(REG_CFG_STAT, rd);
			check_status("status after transfer", make_status(1'b0, 1'b1, 1'b0), status_t'(rd));
		end
		end_test();
	endtask

	task automatic external_receive();
		logic [7:0] rd;
		begin_test("external_receive");
		apb_write(REG_CFG_STAT, make_cfg(1'b1, 1'b0, 6'd2));
		@(posedge i_PCLK);
		i_rx <= 1'b1;
		send_byte(rand_byte());
		apb_read(REG_DATA, rd);
		check_byte("rx held high", 8'hFF, rd);
		@(posedge i_PCLK);
		i_rx <= 1'b0;
		send_byte(rand_byte());
		apb_read(REG_DATA, rd);
		check_byte("rx held low", 8'h00, rd);
		@(posedge i_PCLK);
		i_rx <= 1'b1;
		end_test();
	endtask

	task automatic overrun_then_clear();
		logic [7:0] rd;
		logic [7:0] first;
		bit         seen;
		begin_test("overrun_then_clear");
		first = rand_byte();
		apb_write(REG_CFG_STAT, make_cfg(1'b1, 1'b1, 6'd7));
		apb_write(REG_DATA, first);
		apb_write(REG_CMD, 8'(CMD_START));
		apb_write(REG_DATA, ~first);
		apb_write(REG_CMD, 8'(CMD_START));   // Lands mid transfer
		wait_pkt_rec(LIMIT, seen);
		if (!seen)
		begin
			$display("%s: timeout, o_pkt_rec did not arrive after START", test_name);
			errors++;
		end
		apb_read(REG_DATA, rd);
		check_byte("byte of first START", first, rd);
		apb_read(REG_CFG_STAT, rd);
		check_status("status after overrun", make_status(1'b0, 1'b1, 1'b1), status_t'(rd));
		apb_write(REG_CMD, 8'(CMD_CLEAR));
		apb_read(REG_CFG_STAT, rd);
		check_status("status after clear", make_status(1'b0, 1'b0, 1'b0), status_t'(rd));
		end_test();
	endtask

	task automatic disabled_start();
		logic [7:0] rd;
		bit         seen;
		begin_test("disabled_start");
		apb_write(REG_CFG_STAT, make_cfg(1'b0, 1'b1, 6'd1));
		apb_write(REG_CMD, 8'(CMD_START));
		apb_read(REG_CFG_STAT, rd);
		check_status("status right after START", make_status(1'b0, 1'b0, 1'b0), status_t'(rd));
		wait_pkt_rec(100, seen);
		if (seen)
		begin
			$display("%s: o_pkt_rec was raised while the block was disabled", test_name);
			errors++;
		end
		apb_read(REG_CFG_STAT, rd);
		check_status("status after wait", make_status(1'b0, 1'b0, 1'b0), status_t'(rd));
		end_test();
	endtask

	initial
	begin
		seed       = 32'h988f8347;
		errors     = 0;
		tests      = 0;
		i_PRESETn <= 1'b0;
		i_PSEL    <= 1'b0;
		i_PENABLE <= 1'b0;
		i_PWRITE  <= 1'b0;
		i_PADDR   <= 16'h0000;
		i_PWDATA  <= 8'h00;
		i_rx      <= 1'b1;   // Idle line
		repeat (8) @(posedge i_PCLK);
		i_PRESETn <= 1'b1;
		reset_and_access();
		loopback_transfer();
		external_receive();
		overrun_then_clear();
		disabled_start();
		$display("tests run: %0d, check errors: %0d, assertion failures: %0d",
			tests, errors, apb_spi_top_i.apb_spi_checker_i.fail_count);
		if (errors == 0 && apb_spi_top_i.apb_spi_checker_i.fail_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
